// ==== src/rp_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, counts and buffer addresses
// sample pair and memory write packed structs
//////////////////////////////////////////////////

`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////
  // sample path

  localparam int unsigned SMP_W     = 14;  // ADC/DAC sample width
  localparam int unsigned TRIM_BITS = 2;   // low ADC bits forced to zero

  typedef logic signed [SMP_W-1:0] sample_t;

  // one sample per analog channel
  typedef struct packed {
    sample_t a;
    sample_t b;
  } ch_pair_t;

  //////////////////////////////////////////////////
  // acquisition memory

  localparam int unsigned WORD_W       = 64;
  localparam int unsigned SMP_PER_WORD = 4;
  localparam int unsigned SLOT_W       = WORD_W / SMP_PER_WORD;  // 16b per sample in a word
  localparam int unsigned ACQ_WORDS    = 8;   // words per channel per arm
  localparam int unsigned ADDR_W       = 32;
  localparam int unsigned WORD_BYTES   = 8;   // address step between words

  localparam logic [ADDR_W-1:0] CH_BASE_A = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] CH_BASE_B = 32'h0000_1000;

  localparam int unsigned N_ACQ = 2;  // acquisition channels sharing the port

  // requester index for the write arbiter
  typedef logic [$clog2(N_ACQ)-1:0] acq_idx_t;

  // one write on the shared memory port
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // byte address
    logic [WORD_W-1:0] data;  // first sample in the low slot
  } mem_wr_t;

endpackage

`default_nettype wire

// ==== src/adc_frontend.sv ====
//////////////////////////////////////////////////
// ADC front end
// trims low bits, swaps channels, digital loopback
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module adc_frontend (
  input  wire               adc_clk,
  input  wire               rst_n_i,
  input  rp_pkg::ch_pair_t  adc_dat_i,       // raw converter samples
  input  rp_pkg::ch_pair_t  loop_dat_i,      // clamped DAC-side pair
  input  wire logic         digital_loop_i,  // 1 = capture DAC values
  output rp_pkg::ch_pair_t  acq_dat_o        // pair towards acquisition
);

  rp_pkg::ch_pair_t adc_sel;  // next value of the capture pair

  // clear the noisy low bits of one converter sample
  function automatic rp_pkg::sample_t trim_smp(input rp_pkg::sample_t smp);
    rp_pkg::sample_t res;
    res = smp;
    res[rp_pkg::TRIM_BITS-1:0] = '0;
    return res;
  endfunction

  // loopback bypasses both trim and swap
  always_comb begin
    if (digital_loop_i) begin
      adc_sel = loop_dat_i;
    end else begin
      adc_sel.a = trim_smp(adc_dat_i.b);  // input b drives channel a
      adc_sel.b = trim_smp(adc_dat_i.a);  // input a drives channel b
    end
  end

  // one cycle of latency
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acq_dat_o <= '0;
    end else begin
      acq_dat_o <= adc_sel;
    end
  end

endmodule

`default_nettype wire

// ==== src/dac_backend.sv ====
//////////////////////////////////////////////////
// DAC back end
// generator + controller sum with saturation
// inversion for the neg-slope DAC, pin swap, reset
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_backend (
  input  wire               adc_clk,
  input  wire               rst_n_i,
  input  rp_pkg::ch_pair_t  gen_dat_i,    // arbitrary generator samples
  input  rp_pkg::ch_pair_t  pid_dat_i,    // controller samples
  output rp_pkg::ch_pair_t  loop_dat_o,   // clamped sum, two's complement
  output rp_pkg::ch_pair_t  dac_dat_o,    // converter pins, inverted
  output logic              dac_reset_o
);

  rp_pkg::ch_pair_t inv_q;  // inverted pair, first stage

  // add with one guard bit, then clamp to the signed sample range
  function automatic rp_pkg::sample_t sat_sum(
    input rp_pkg::sample_t x,
    input rp_pkg::sample_t y
  );
    logic signed [rp_pkg::SMP_W:0] sum;
    sum = x + y;
    if (sum[rp_pkg::SMP_W] != sum[rp_pkg::SMP_W-1]) begin
      // overflow, sign bit tells which rail
      return {sum[rp_pkg::SMP_W], {(rp_pkg::SMP_W-1){~sum[rp_pkg::SMP_W]}}};
    end
    return sum[rp_pkg::SMP_W-1:0];
  endfunction

  always_comb begin
    loop_dat_o.a = sat_sum(gen_dat_i.a, pid_dat_i.a);
    loop_dat_o.b = sat_sum(gen_dat_i.b, pid_dat_i.b);
  end

  //////////////////////////////////////////////////
  // output pipe, two stages

  always_ff @(posedge adc_clk) begin
    inv_q.a     <= ~loop_dat_o.a;  // converter counts down
    inv_q.b     <= ~loop_dat_o.b;
    dac_dat_o.a <= inv_q.b;        // ch b -> dac a
    dac_dat_o.b <= inv_q.a;        // ch a -> dac b
  end

  // converter held in reset until the first edge after release
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_reset_o <= 1'b1;
    end else begin
      dac_reset_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/acq_channel.sv ====
//////////////////////////////////////////////////
// one acquisition channel
// packs samples into memory words and requests
// writes, single pending word, overflow flag
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module acq_channel #(
  parameter logic [rp_pkg::ADDR_W-1:0] BASE_ADDR = '0  // buffer start, bytes
) (
  input  wire              adc_clk,
  input  wire              rst_n_i,
  input  wire logic        arm_i,        // start pulse
  input  rp_pkg::sample_t  smp_i,
  output logic             req_valid_o,
  output rp_pkg::mem_wr_t  req_o,
  input  wire logic        req_ready_i,
  output logic             done_o,       // all words written
  output logic             overflow_o    // sticky flag for a dropped word
);

  logic [$clog2(rp_pkg::SMP_PER_WORD)-1:0] smp_cnt;   // samples in current word
  logic [$clog2(rp_pkg::ACQ_WORDS)-1:0]    word_cnt;  // index of current word
  logic                                    cap_on;    // collecting samples
  logic                                    fin_q;     // last word done, draining

  logic [rp_pkg::WORD_W-1:0] pack_q;    // shift register of samples
  logic [rp_pkg::WORD_W-1:0] smp_word;  // pack_q with this cycle's sample
  logic [rp_pkg::SLOT_W-1:0] smp_ext;   // sign extended sample
  logic [rp_pkg::ADDR_W-1:0] word_off;

  logic arm_go;     // arm accepted
  logic word_end;   // fourth sample of a word this cycle
  logic last_word;
  logic slot_busy;  // pending word still there after this edge
  logic load_word;

  //////////////////////////////////////////////////
  // datapath helpers

  assign smp_ext  = {{(rp_pkg::SLOT_W-rp_pkg::SMP_W){smp_i[rp_pkg::SMP_W-1]}}, smp_i};
  assign smp_word = {smp_ext, pack_q[rp_pkg::WORD_W-1:rp_pkg::SLOT_W]};  // oldest lands low
  assign word_off = word_cnt * rp_pkg::WORD_BYTES;

  assign arm_go    = arm_i && !cap_on && !fin_q;  // ignored while busy
  assign word_end  = smp_cnt == rp_pkg::SMP_PER_WORD - 1;
  assign last_word = word_cnt == rp_pkg::ACQ_WORDS - 1;
  assign slot_busy = req_valid_o && !req_ready_i;
  assign load_word = cap_on && word_end && !slot_busy;

  //////////////////////////////////////////////////
  // control

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cap_on      <= 1'b0;
      fin_q       <= 1'b0;
      smp_cnt     <= '0;
      word_cnt    <= '0;
      req_valid_o <= 1'b0;
      done_o      <= 1'b0;
      overflow_o  <= 1'b0;
    end else begin
      if (req_valid_o && req_ready_i) begin
        req_valid_o <= 1'b0;  // transfer done
      end
      if (arm_go) begin
        cap_on     <= 1'b1;
        smp_cnt    <= 1'b1;  // arm cycle sample is the first one
        word_cnt   <= '0;
        done_o     <= 1'b0;
        overflow_o <= 1'b0;
      end else if (cap_on) begin
        smp_cnt <= smp_cnt + 1'b1;  // wraps at a word boundary
        if (word_end) begin
          word_cnt <= word_cnt + 1'b1;
          if (slot_busy) begin
            overflow_o <= 1'b1;  // new word dropped and capture goes on
          end else begin
            req_valid_o <= 1'b1;
          end
          if (last_word) begin
            cap_on <= 1'b0;
            fin_q  <= 1'b1;
          end
        end
      end else if (fin_q && !slot_busy) begin
        fin_q  <= 1'b0;  // last pending word gone
        done_o <= 1'b1;
      end
    end
  end

  // word payload and address
  always_ff @(posedge adc_clk) begin
    if (arm_go || cap_on) begin
      pack_q <= smp_word;
    end
    if (load_word) begin
      req_o.addr <= BASE_ADDR + word_off;
      req_o.data <= smp_word;
    end
  end

endmodule

`default_nettype wire

// ==== src/wr_arbiter.sv ====
//////////////////////////////////////////////////
// round-robin arbiter for the shared write port
// one-entry output slot
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wr_arbiter (
  input  wire                                   adc_clk,
  input  wire                                   rst_n_i,
  input  wire logic [rp_pkg::N_ACQ-1:0]         req_valid_i,
  input  rp_pkg::mem_wr_t [rp_pkg::N_ACQ-1:0]   req_i,
  output logic [rp_pkg::N_ACQ-1:0]              req_ready_o,
  output logic                                  mem_wr_valid_o,
  output rp_pkg::mem_wr_t                       mem_wr_o,
  input  wire logic                             mem_wr_ready_i
);

  rp_pkg::acq_idx_t last_q;   // requester granted last
  rp_pkg::acq_idx_t gnt_idx;
  logic             gnt_any;
  logic             slot_free;  // empty or draining now
  logic             take;

  assign slot_free = !mem_wr_valid_o || mem_wr_ready_i;
  assign take      = gnt_any && slot_free;

  // search starts just after the last winner
  always_comb begin : rr_pick
    int unsigned idx;
    gnt_any = 1'b0;
    gnt_idx = last_q;
    for (int unsigned k = 1; k <= rp_pkg::N_ACQ; k++) begin
      idx = (last_q + k) % rp_pkg::N_ACQ;
      if (!gnt_any && req_valid_i[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = rp_pkg::acq_idx_t'(idx);
      end
    end
  end

  always_comb begin
    req_ready_o = '0;
    if (take) begin
      req_ready_o[gnt_idx] = 1'b1;  // only the winner sees ready
    end
  end

  //////////////////////////////////////////////////
  // output slot

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_wr_valid_o <= 1'b0;
      last_q         <= '0;
    end else if (take) begin
      mem_wr_valid_o <= 1'b1;
      last_q         <= gnt_idx;
    end else if (mem_wr_ready_i) begin
      mem_wr_valid_o <= 1'b0;  // drained, nothing new
    end
  end

  always_ff @(posedge adc_clk) begin
    if (take) begin
      mem_wr_o <= req_i[gnt_idx];
    end
  end

endmodule

`default_nettype wire

// ==== src/rp_core_top.sv ====
//////////////////////////////////////////////////
// analog core top level
// ADC front end, DAC back end, two capture
// channels and the write port arbiter
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rp_core_top (
  input  wire                           adc_clk,
  input  wire                           rst_n_i,
  // analog data
  input  rp_pkg::ch_pair_t              adc_dat_i,
  input  rp_pkg::ch_pair_t              gen_dat_i,
  input  rp_pkg::ch_pair_t              pid_dat_i,
  input  wire logic                     digital_loop_i,
  output rp_pkg::ch_pair_t              dac_dat_o,
  output logic                          dac_reset_o,
  // acquisition control
  input  wire logic                     arm_i,
  output logic                          done_o,
  output logic [rp_pkg::N_ACQ-1:0]      overflow_o,
  // memory write port
  output logic                          mem_wr_valid_o,
  output rp_pkg::mem_wr_t               mem_wr_o,
  input  wire logic                     mem_wr_ready_i
);

  rp_pkg::ch_pair_t loop_dat;  // clamped DAC pair for loopback
  rp_pkg::ch_pair_t acq_dat;   // capture pair

  logic            [rp_pkg::N_ACQ-1:0] req_valid;
  rp_pkg::mem_wr_t [rp_pkg::N_ACQ-1:0] req;
  logic            [rp_pkg::N_ACQ-1:0] req_ready;
  logic            [rp_pkg::N_ACQ-1:0] done;

  //////////////////////////////////////////////////
  // analog path

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .loop_dat_i     (loop_dat),
    .digital_loop_i (digital_loop_i),
    .acq_dat_o      (acq_dat)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .gen_dat_i   (gen_dat_i),
    .pid_dat_i   (pid_dat_i),
    .loop_dat_o  (loop_dat),
    .dac_dat_o   (dac_dat_o),
    .dac_reset_o (dac_reset_o)
  );

  //////////////////////////////////////////////////
  // oscilloscope write path

  acq_channel #(.BASE_ADDR (rp_pkg::CH_BASE_A)) i_acq_a (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .arm_i       (arm_i),
    .smp_i       (acq_dat.a),
    .req_valid_o (req_valid[0]),
    .req_o       (req[0]),
    .req_ready_i (req_ready[0]),
    .done_o      (done[0]),
    .overflow_o  (overflow_o[0])
  );

  acq_channel #(.BASE_ADDR (rp_pkg::CH_BASE_B)) i_acq_b (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .arm_i       (arm_i),
    .smp_i       (acq_dat.b),
    .req_valid_o (req_valid[1]),
    .req_o       (req[1]),
    .req_ready_i (req_ready[1]),
    .done_o      (done[1]),
    .overflow_o  (overflow_o[1])
  );

  wr_arbiter i_arb (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .mem_wr_valid_o (mem_wr_valid_o),
    .mem_wr_o       (mem_wr_o),
    .mem_wr_ready_i (mem_wr_ready_i)
  );

  assign done_o = &done;  // both buffers complete

endmodule

`default_nettype wire

// ==== include/rp_tb_table.svh ====
//////////////////////////////////////////////////
// testbench table, DAC and loopback stimulus
// expected converter pins and captured pairs
//////////////////////////////////////////////////

`ifndef RP_TB_TABLE_SVH
`define RP_TB_TABLE_SVH

typedef struct packed {
  rp_pkg::ch_pair_t gen;   // generator a/b
  rp_pkg::ch_pair_t pid;   // controller a/b
  rp_pkg::ch_pair_t adc;   // raw ADC a/b
  logic             loop;  // digital loopback
  rp_pkg::ch_pair_t dac;   // expected pins, inverted and swapped
  rp_pkg::ch_pair_t cap;   // expected captured pair
} tbl_row_t;

// one row per captured word
localparam int TBL_ROWS = 8;

// columns: gen, pid, adc, loop, expected dac, expected capture
localparam tbl_row_t TBL [TBL_ROWS] = '{
  // in range, ADC low bits trimmed
  '{'{14'sd100, -14'sd200}, '{14'sd50, 14'sd25}, '{14'h0123, 14'h3abd}, 1'b0,
    '{14'h00ae, 14'h3f69}, '{14'h3abc, 14'h0120}},
  // a overflows high, b low
  '{'{14'sd8000, -14'sd8000}, '{14'sd500, -14'sd500}, '{14'h1fff, 14'h2003}, 1'b0,
    '{14'h1fff, 14'h2000}, '{14'h2000, 14'h1ffc}},
  '{'{14'sd0, 14'sd0}, '{14'sd0, 14'sd0}, '{14'h0007, 14'h000e}, 1'b0,
    '{14'h3fff, 14'h3fff}, '{14'h000c, 14'h0004}},
  // loopback, sums unswapped and untrimmed
  '{'{14'sd1234, -14'sd4321}, '{-14'sd34, 14'sd321}, '{14'h1555, 14'h2aaa}, 1'b1,
    '{14'h0f9f, 14'h3b4f}, '{14'h04b0, 14'h3060}},
  // loopback, a below min, b above max
  '{'{14'sh2000, 14'sd8191}, '{-14'sd1, 14'sd1}, '{14'h0abc, 14'h3333}, 1'b1,
    '{14'h2000, 14'h1fff}, '{14'h2000, 14'h1fff}},
  // exactly on both rails
  '{'{14'sd4096, -14'sd4096}, '{14'sd4095, -14'sd4096}, '{14'h0000, 14'h3fff}, 1'b1,
    '{14'h1fff, 14'h2000}, '{14'h1fff, 14'h2000}},
  '{'{-14'sd1, 14'sd3}, '{-14'sd1, -14'sd7}, '{14'h2fff, 14'h1001}, 1'b0,
    '{14'h0003, 14'h0001}, '{14'h1000, 14'h2ffc}},
  // only b saturates
  '{'{14'sd3000, 14'sd2000}, '{14'sd3000, 14'sd7000}, '{14'h3ffd, 14'h0ff2}, 1'b0,
    '{14'h2000, 14'h288f}, '{14'h0ff0, 14'h3ffc}}
};

`endif

// ==== tb/tb_rp_core.sv ====
//////////////////////////////////////////////////
// testbench for the analog core top level
// DAC table, loopback and ramp capture, overflow
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_rp_core;

  localparam int CAP_SMP = rp_pkg::ACQ_WORDS * rp_pkg::SMP_PER_WORD;  // samples per arm

  logic                       adc_clk;
  logic                       rst_n_i;
  rp_pkg::ch_pair_t           adc_dat_i;
  rp_pkg::ch_pair_t           gen_dat_i;
  rp_pkg::ch_pair_t           pid_dat_i;
  logic                       digital_loop_i;
  rp_pkg::ch_pair_t           dac_dat_o;
  logic                       dac_reset_o;
  logic                       arm_i;
  logic                       done_o;
  logic [rp_pkg::N_ACQ-1:0]   overflow_o;
  logic                       mem_wr_valid_o;
  rp_pkg::mem_wr_t            mem_wr_o;
  logic                       mem_wr_ready_i;

  `include "rp_tb_table.svh"

  // table steps, worst case drain per word, margin
  localparam int TIMEOUT_CYC = TBL_ROWS * 4 + rp_pkg::ACQ_WORDS * rp_pkg::N_ACQ * 20 + 100;

  rp_pkg::mem_wr_t wr_q [$];         // writes seen on the port
  rp_pkg::sample_t exp_a [CAP_SMP];  // expected capture of channel a
  rp_pkg::sample_t exp_b [CAP_SMP];
  logic            hold_low = 1'b0;  // force ready low
  integer          seed = 32'hedd9;
  int              cyc_cnt = 0;

  rp_core_top dut (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .gen_dat_i      (gen_dat_i),
    .pid_dat_i      (pid_dat_i),
    .digital_loop_i (digital_loop_i),
    .dac_dat_o      (dac_dat_o),
    .dac_reset_o    (dac_reset_o),
    .arm_i          (arm_i),
    .done_o         (done_o),
    .overflow_o     (overflow_o),
    .mem_wr_valid_o (mem_wr_valid_o),
    .mem_wr_o       (mem_wr_o),
    .mem_wr_ready_i (mem_wr_ready_i)
  );

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 50 MHz
  end

  //////////////////////////////////////////////////
  // failure reporting and compare

  task automatic fail_now();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [127:0] exp_v,
                           input logic [127:0] act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
      fail_now();
    end
  endtask

  always @(posedge adc_clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt > TIMEOUT_CYC) begin
      $display("timeout, DUT did not finish within %0d cycles", TIMEOUT_CYC);
      fail_now();
    end
  end

  // ready driver and port monitor share one process on the falling edge
  initial begin : ready_drive
    logic [31:0] rnd;
    mem_wr_ready_i = 1'b0;
    forever begin
      @(negedge adc_clk);
      rnd = $random(seed);
      if (hold_low) begin
        mem_wr_ready_i = 1'b0;
      end else begin
        mem_wr_ready_i = rnd[0] || !mem_wr_ready_i;  // never low twice running
      end
      if (mem_wr_valid_o && mem_wr_ready_i) begin
        wr_q.push_back(mem_wr_o);  // transfer on the coming edge
      end
    end
  end

  //////////////////////////////////////////////////
  // capture checks

  // four 16b sign extended samples with the oldest in the low slot
  function automatic logic [rp_pkg::WORD_W-1:0] pack_word(input logic use_b, input int w);
    logic [rp_pkg::WORD_W-1:0] word;
    rp_pkg::sample_t           smp;
    word = '0;
    for (int i = 0; i < rp_pkg::SMP_PER_WORD; i++) begin
      smp = use_b ? exp_b[w * rp_pkg::SMP_PER_WORD + i] : exp_a[w * rp_pkg::SMP_PER_WORD + i];
      word[16*i +: 16] = {{2{smp[13]}}, smp};
    end
    return word;
  endfunction

  task automatic check_word(input string name, input logic use_b, input int idx,
                            input rp_pkg::mem_wr_t wr);
    logic [rp_pkg::ADDR_W-1:0] base;
    base = use_b ? rp_pkg::CH_BASE_B : rp_pkg::CH_BASE_A;
    if (idx >= rp_pkg::ACQ_WORDS) begin
      $display("%s wrote more words than one capture holds", name);
      fail_now();
    end else begin
      check_val($sformatf("%s addr %0d", name, idx), base + idx * rp_pkg::WORD_BYTES,
                wr.addr);
      check_val($sformatf("%s data %0d", name, idx), pack_word(use_b, idx), wr.data);
    end
  endtask

  // per channel order is kept through the arbiter
  task automatic check_writes(input string tag);
    int n_a;
    int n_b;
    n_a = 0;
    n_b = 0;
    foreach (wr_q[i]) begin
      if (wr_q[i].addr < rp_pkg::CH_BASE_B) begin
        check_word({tag, " ch a"}, 1'b0, n_a, wr_q[i]);
        n_a++;
      end else begin
        check_word({tag, " ch b"}, 1'b1, n_b, wr_q[i]);
        n_b++;
      end
    end
    check_val({tag, " words a"}, rp_pkg::ACQ_WORDS, n_a);
    check_val({tag, " words b"}, rp_pkg::ACQ_WORDS, n_b);
  endtask

  task automatic wait_capture_end();
    while (!done_o) @(negedge adc_clk);
    while (mem_wr_valid_o) @(negedge adc_clk);  // last word leaves the slot
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin : main_seq
    int r;
    rst_n_i        = 1'b0;
    adc_dat_i      = '0;
    gen_dat_i      = '0;
    pid_dat_i      = '0;
    digital_loop_i = 1'b0;
    arm_i          = 1'b0;
    repeat (8) @(negedge adc_clk);
    check_val("reset dac_reset_o", 1, dac_reset_o);
    check_val("reset mem_wr_valid_o", 0, mem_wr_valid_o);
    check_val("reset done_o", 0, done_o);
    rst_n_i = 1'b1;
    @(negedge adc_clk);
    check_val("dac_reset_o after release", 0, dac_reset_o);

    // one table row per word and arm one step late so sample 0 is row 0
    @(posedge adc_clk);
    wr_q.delete();
    for (int s = 0; s < CAP_SMP; s++) begin
      @(negedge adc_clk);
      r              = s / rp_pkg::SMP_PER_WORD;
      gen_dat_i      = TBL[r].gen;
      pid_dat_i      = TBL[r].pid;
      adc_dat_i      = TBL[r].adc;
      digital_loop_i = TBL[r].loop;
      arm_i          = (s == 1);
      exp_a[s]       = TBL[r].cap.a;
      exp_b[s]       = TBL[r].cap.b;
      if (s % rp_pkg::SMP_PER_WORD == 2) begin
        check_val($sformatf("dac row %0d", r), TBL[r].dac, dac_dat_o);  // two edges later
      end
    end
    wait_capture_end();
    check_writes("table");
    check_val("table overflow", 0, overflow_o);

    // ADC ramp with the low bits set
    @(posedge adc_clk);
    wr_q.delete();
    for (int s = 0; s < CAP_SMP; s++) begin
      @(negedge adc_clk);
      digital_loop_i = 1'b0;
      adc_dat_i.a    = rp_pkg::sample_t'(s * 8 + 3);
      adc_dat_i.b    = rp_pkg::sample_t'(32'h2000 + s * 4 + 2);
      arm_i          = (s == 1);
      exp_a[s]       = rp_pkg::sample_t'(32'h2000 + s * 4);  // from input b
      exp_b[s]       = rp_pkg::sample_t'(s * 8);
    end
    wait_capture_end();
    check_writes("ramp");
    check_val("ramp overflow", 0, overflow_o);

    // stalled port makes both channels drop words
    @(posedge adc_clk);
    hold_low = 1'b1;
    @(negedge adc_clk);
    arm_i = 1'b1;
    @(negedge adc_clk);
    arm_i = 1'b0;
    repeat (CAP_SMP) @(negedge adc_clk);
    check_val("overflow set", 2'b11, overflow_o);
    @(posedge adc_clk);
    hold_low = 1'b0;
    @(negedge adc_clk);
    wait_capture_end();
    @(negedge adc_clk);
    arm_i = 1'b1;
    @(negedge adc_clk);
    arm_i = 1'b0;
    check_val("overflow after re-arm", 0, overflow_o);
    check_val("done_o after re-arm", 0, done_o);
    wait_capture_end();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
src/rp_pkg.sv
src/adc_frontend.sv
src/dac_backend.sv
src/acq_channel.sv
src/wr_arbiter.sv
src/rp_core_top.sv
tb/tb_rp_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
# exit status is nonzero when the testbench stops on an error
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_rp_core \
  -f build.f \
  --Mdir obj_dir -o tb_rp_core

./obj_dir/tb_rp_core
